// ==== src.f ====
+incdir+logic
logic/alu_pkg.sv
logic/alu_operand_stage.sv
logic/alu_int_arith.sv
logic/alu_logic_unit.sv
logic/alu_cmp_shift.sv
logic/alu_float_sign.sv
logic/alu_result_select.sv
logic/alu_top.sv
verif/alu_tb.sv

// ==== verif/alu_tb.sv ====
/*
  Random pipelined check of alu_top against a reference model.
  One op is issued every cycle and its result is checked two edges after issue.
*/
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_tb import alu_pkg::*; ();

	typedef struct packed {
		alu_op_e     op;
		alu_word_t   in1;
		alu_word_t   in2;
		logic [31:0] due;  // edge_cnt value once out holds the result
	} stim_t;

	logic      clk;
	logic      arst_n;
	alu_op_e   op;
	alu_word_t in1;
	alu_word_t in2;
	alu_word_t out;

	integer    seed = 32'hce78c221;
	int        edge_cnt = 0;
	stim_t     stim_q[$];       // Issued and not yet checked
	string     name_q[$];

	// Operand and opcode pools
	alu_op_e   two_ops[8]     = '{OP_ADD, OP_MLT, OP_SGN, OP_AND, OP_ORR, OP_XOR, OP_LAN, OP_LOR};
	alu_op_e   unary_ops[10]  = '{OP_NEG, OP_NEG_M, OP_ABS, OP_ABS_M, OP_PST, OP_PST_M,
	                              OP_INV, OP_INV_M, OP_LIN, OP_LIN_M};
	alu_op_e   cmp_ops[3]     = '{OP_LES, OP_GRE, OP_EQU};
	alu_op_e   shift_ops[3]   = '{OP_SHL, OP_SHR, OP_SRS};
	alu_op_e   float_ops[7]   = '{OP_F_SGN, OP_F_NEG, OP_F_NEG_M, OP_F_ABS, OP_F_ABS_M,
	                              OP_F_PST, OP_F_PST_M};
	logic [5:0] dropped_ops[6] = '{6'd3, 6'd6, 6'd8, 6'd23, 6'd39, 6'd63};
	alu_word_t edge_vals[3]   = '{32'h0000_0000, 32'h8000_0000, 32'hffff_ffff};
	alu_word_t shift_amts[4]  = '{32'd0, 32'd31, 32'd32, 32'hffff_ffff};

	alu_top dut0 (.clk(clk), .arst_n(arst_n), .op(op), .in1(in1), .in2(in2), .out(out));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns
	end

	always @(posedge clk) edge_cnt <= edge_cnt + 1;

	// ********************
	// Model
	// ********************
	function automatic alu_word_t alu_ref(input alu_op_e op, input alu_word_t in1,
	                                      input alu_word_t in2);
		alu_word_t u;  // Unary operand
		alu_word_t r;
		u = (op inside {OP_NEG_M, OP_F_NEG_M, OP_ABS_M, OP_F_ABS_M, OP_PST_M, OP_F_PST_M,
		                OP_INV_M, OP_LIN_M}) ? in1 : in2;
		case (op)
			OP_NOP:               r = in2;
			OP_LOD:               r = in1;
			OP_ADD:               r = in1 + in2;
			OP_MLT:               r = in1 * in2;
			OP_SGN:               r = (in1[31] == in2[31]) ? in2 : -in2;
			OP_F_SGN:             r = {in1[31], in2[30:0]};
			OP_NEG, OP_NEG_M:     r = -u;
			OP_F_NEG, OP_F_NEG_M: r = u ^ 32'h8000_0000;
			OP_ABS, OP_ABS_M:     r = u[31] ? -u : u;
			OP_F_ABS, OP_F_ABS_M: r = u & 32'h7fff_ffff;
			OP_PST, OP_PST_M:     r = u[31] ? 32'h0 : u;
			OP_F_PST, OP_F_PST_M: r = u[31] ? 32'h4000_0000 : u;  // Float zero
			OP_AND:               r = in1 & in2;
			OP_ORR:               r = in1 | in2;
			OP_XOR:               r = in1 ^ in2;
			OP_INV, OP_INV_M:     r = ~u;
			OP_LAN:               r = (in1 != 0 && in2 != 0) ? 32'd1 : 32'd0;
			OP_LOR:               r = (in1 != 0 || in2 != 0) ? 32'd1 : 32'd0;
			OP_LIN, OP_LIN_M:     r = (u == 0) ? 32'd1 : 32'd0;
			OP_LES:               r = ($signed(in1) < $signed(in2)) ? 32'd1 : 32'd0;
			OP_GRE:               r = ($signed(in1) > $signed(in2)) ? 32'd1 : 32'd0;
			OP_EQU:               r = (in1 == in2) ? 32'd1 : 32'd0;
			OP_SHL:               r = in1 << in2;  // 32 or more clears
			OP_SHR:               r = in1 >> in2;
			OP_SRS:               r = $signed(in1) >>> in2;
			default:              r = 32'h0;
		endcase
		return r;
	endfunction

	function automatic alu_word_t rnd_word();
		return $random(seed);
	endfunction

	task automatic check(input string name, input alu_word_t expected, input alu_word_t actual);
		if (expected !== actual) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			$display(">>> FAIL");
			$fatal(1, "Result mismatch in %s", name);
		end
	endtask

	task automatic push_expect(input string name, input alu_op_e o, input alu_word_t a,
	                           input alu_word_t b, input int due);
		stim_t s;
		s.op  = o;
		s.in1 = a;
		s.in2 = b;
		s.due = due;
		stim_q.push_back(s);
		name_q.push_back(name);
	endtask

	// Drive on the next rising edge and queue the expected result
	task automatic issue(input string name, input alu_op_e o, input alu_word_t a,
	                     input alu_word_t b);
		@(posedge clk);
		op  <= o;
		in1 <= a;
		in2 <= b;
		push_expect(name, o, a, b, edge_cnt + `ALU_LATENCY + 1);
	endtask

	task automatic release_reset();
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		// Cleared pipe reads as NOP on zeros
		for (int k = 1; k <= `ALU_LATENCY; k++) begin
			push_expect("reset_flush", OP_NOP, 32'h0, 32'h0, edge_cnt + k + 1);
		end
	endtask

	// ********************
	// Compare
	// ********************
	initial begin : compare
		stim_t s;
		string nm;
		forever begin
			@(negedge clk);  // out stable mid-cycle
			if (stim_q.size() != 0 && stim_q[0].due == edge_cnt) begin
				s  = stim_q.pop_front();
				nm = name_q.pop_front();
				check(nm, alu_ref(s.op, s.in1, s.in2), out);
			end
		end
	end

	// ********************
	// Stimulus
	// ********************
	initial begin : stimulus
		alu_word_t r;
		alu_word_t b;
		int        n;
		op     = OP_NOP;
		in1    = 32'h0;
		in2    = 32'h0;
		arst_n = 1'b0;
		release_reset();
		issue("nop_first", OP_NOP, rnd_word(), rnd_word());

		// Back-to-back ops with in1 zero now and then
		repeat (80) begin
			r = rnd_word();
			issue("two_operand", two_ops[rnd_word() % 8], (r[1:0] == 0) ? 32'h0 : r, rnd_word());
		end

		// Truth-table corners of LAN and LOR
		for (int k = 0; k < 4; k++) begin
			r = k[0] ? (rnd_word() | 32'h1) : 32'h0;
			b = k[1] ? (rnd_word() | 32'h1) : 32'h0;
			issue("logical", OP_LAN, r, b);
			issue("logical", OP_LOR, r, b);
		end

		foreach (unary_ops[i]) begin
			foreach (edge_vals[j]) begin
				issue("unary", unary_ops[i], edge_vals[j], rnd_word());
				issue("unary", unary_ops[i], rnd_word(), edge_vals[j]);
			end
			issue("unary", unary_ops[i], rnd_word(), rnd_word());
		end

		foreach (cmp_ops[i]) begin
			r = rnd_word();
			issue("compare", cmp_ops[i], r, r);
			issue("compare", cmp_ops[i], r | 32'h8000_0000, r & 32'h7fff_ffff);
			issue("compare", cmp_ops[i], r & 32'h7fff_ffff, r | 32'h8000_0000);
			issue("compare", cmp_ops[i], rnd_word(), rnd_word());
		end

		foreach (shift_ops[i]) begin
			foreach (shift_amts[j]) begin
				issue("shift", shift_ops[i], rnd_word() | 32'h8000_0000, shift_amts[j]);
				issue("shift", shift_ops[i], rnd_word() & 32'h7fff_ffff, shift_amts[j]);
			end
			issue("shift", shift_ops[i], rnd_word(), rnd_word() & 32'h1f);
			issue("shift", shift_ops[i], rnd_word(), rnd_word() | 32'h100);  // Large amount
		end

		// All four sign pairings, so F_PST also sees negative operands
		foreach (float_ops[i]) begin
			issue("float_sign", float_ops[i], rnd_word() | 32'h8000_0000,
			      rnd_word() | 32'h8000_0000);
			issue("float_sign", float_ops[i], rnd_word() & 32'h7fff_ffff,
			      rnd_word() & 32'h7fff_ffff);
			issue("float_sign", float_ops[i], rnd_word() | 32'h8000_0000,
			      rnd_word() & 32'h7fff_ffff);
			issue("float_sign", float_ops[i], rnd_word() & 32'h7fff_ffff,
			      rnd_word() | 32'h8000_0000);
		end

		issue("nop", OP_NOP, rnd_word(), rnd_word());
		issue("lod", OP_LOD, rnd_word(), rnd_word());
		foreach (dropped_ops[i]) begin
			issue("dropped", alu_op_e'(dropped_ops[i]), rnd_word(), rnd_word());
		end

		// Drain the pipe
		n = 0;
		while (stim_q.size() != 0 && n <= 2 * `ALU_LATENCY + 4) begin
			@(negedge clk);
			n++;
		end
		if (stim_q.size() != 0) begin
			$display("Timeout: %0d results never appeared on out", stim_q.size());
			$display(">>> FAIL");
			$fatal(1, "Pipeline drain timed out");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

// ==== logic/alu_top.sv ====
/*
  Pipelined ALU, one operation per cycle, result two edges after sampling.
  No valid strobe or back-pressure; out always reflects the op issued two edges before.
*/
`timescale 1ns/1ps

module alu_top import alu_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  alu_op_e   op,
	input  alu_word_t in1,   // Memory operand
	input  alu_word_t in2,   // Accumulator operand
	output alu_word_t out
);

	alu_operands_t  opnd;
	int_results_t   int_res;
	logic_results_t logic_res;
	cmp_results_t   cmp_res;
	float_results_t float_res;

	// Stage 1, operand register
	alu_operand_stage u_operand_stage (
		.clk    (clk),
		.arst_n (arst_n),
		.op     (op),
		.in1    (in1),
		.in2    (in2),
		.opnd   (opnd)
	);

	// Combinational units between the two registers
	alu_int_arith  u_int_arith  (.opnd(opnd), .res(int_res));
	alu_logic_unit u_logic_unit (.opnd(opnd), .res(logic_res));
	alu_cmp_shift  u_cmp_shift  (.opnd(opnd), .res(cmp_res));
	alu_float_sign u_float_sign (.opnd(opnd), .res(float_res));

	// Stage 2, mux and output register
	alu_result_select u_result_select (
		.clk       (clk),
		.arst_n    (arst_n),
		.opnd      (opnd),
		.int_res   (int_res),
		.logic_res (logic_res),
		.cmp_res   (cmp_res),
		.float_res (float_res),
		.out       (out)
	);

endmodule

// ==== logic/alu_result_select.sv ====
/*
  Output stage. Picks one unit result by opcode and registers it on out.
  Unused and unsupported opcodes give zero.
*/
`timescale 1ns/1ps

module alu_result_select import alu_pkg::*; (
	input  logic           clk,
	input  logic           arst_n,
	input  alu_operands_t  opnd,
	input  int_results_t   int_res,
	input  logic_results_t logic_res,
	input  cmp_results_t   cmp_res,
	input  float_results_t float_res,
	output alu_word_t      out
);

	alu_word_t out_nxt;

	// ********************
	// Result mux
	// ********************
	always_comb begin
		case (opnd.op)
			OP_NOP:                 out_nxt = opnd.y;
			OP_LOD:                 out_nxt = opnd.x;
			OP_ADD:                 out_nxt = int_res.add;
			OP_MLT:                 out_nxt = int_res.mlt;
			OP_SGN:                 out_nxt = int_res.sgn;
			OP_F_SGN:               out_nxt = float_res.fsgn;
			// Unary pairs share a field since the operand is chosen upstream
			OP_NEG,   OP_NEG_M:     out_nxt = int_res.neg;
			OP_F_NEG, OP_F_NEG_M:   out_nxt = float_res.fneg;
			OP_ABS,   OP_ABS_M:     out_nxt = int_res.abs;
			OP_F_ABS, OP_F_ABS_M:   out_nxt = float_res.fabs;
			OP_PST,   OP_PST_M:     out_nxt = int_res.pst;
			OP_F_PST, OP_F_PST_M:   out_nxt = float_res.fpst;
			OP_AND:                 out_nxt = logic_res.band;
			OP_ORR:                 out_nxt = logic_res.bor;
			OP_XOR:                 out_nxt = logic_res.bxor;
			OP_INV,   OP_INV_M:     out_nxt = logic_res.inv;
			OP_LAN:                 out_nxt = logic_res.lan;
			OP_LOR:                 out_nxt = logic_res.lor;
			OP_LIN,   OP_LIN_M:     out_nxt = logic_res.lin;
			OP_LES:                 out_nxt = cmp_res.les;
			OP_GRE:                 out_nxt = cmp_res.gre;
			OP_EQU:                 out_nxt = cmp_res.equ;
			OP_SHL:                 out_nxt = cmp_res.shl;
			OP_SHR:                 out_nxt = cmp_res.shr;
			OP_SRS:                 out_nxt = cmp_res.srs;
			default:                out_nxt = '0;  // Dropped ops such as DIV
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out <= '0;
		end else begin
			out <= out_nxt;
		end
	end

	// X on out means an unknown operand reached the pipe
	a_out_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(out));

endmodule

// ==== logic/alu_float_sign.sv ====
/*
  Float ops that touch only the sign. Exponent and mantissa pass unchanged,
  so no rounding or normalization happens here.
*/
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_float_sign import alu_pkg::*; (
	input  alu_operands_t  opnd,
	output float_results_t res
);

	logic                sign_x;
	logic                sign_a;
	logic [`ALU_EXP-1:0] exp_y;
	logic [`ALU_MAN-1:0] man_y;
	logic [`ALU_EXP-1:0] exp_a;
	logic [`ALU_MAN-1:0] man_a;

	// Field split, sign sits just above the exponent
	assign sign_x = opnd.x[`ALU_EXP+`ALU_MAN];
	assign exp_y  = opnd.y[`ALU_EXP+`ALU_MAN-1:`ALU_MAN];
	assign man_y  = opnd.y[`ALU_MAN-1:0];
	assign sign_a = opnd.a[`ALU_EXP+`ALU_MAN];
	assign exp_a  = opnd.a[`ALU_EXP+`ALU_MAN-1:`ALU_MAN];
	assign man_a  = opnd.a[`ALU_MAN-1:0];

	assign res.fsgn = {sign_x, exp_y, man_y};    // Sign of x on magnitude of y
	assign res.fneg = {~sign_a, exp_a, man_a};
	assign res.fabs = {1'b0, exp_a, man_a};
	assign res.fpst = sign_a ? FLOAT_ZERO : opnd.a;

endmodule

// ==== logic/alu_cmp_shift.sv ====
/*
  Signed compares and shifts of x by y.
  The whole of y is the shift amount; 32 or more empties the word (sign fill for SRS).
*/
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_cmp_shift import alu_pkg::*; (
	input  alu_operands_t opnd,
	output cmp_results_t  res
);

	logic                          lt;
	logic                          gt;
	logic                          eq;
	logic                          over;     // Amount past the word
	logic [$clog2(`ALU_WIDTH)-1:0] sh_amt;
	logic                          sign_x;

	// ********************
	// Compares
	// ********************
	assign lt = $signed(opnd.x) < $signed(opnd.y);
	assign gt = $signed(opnd.x) > $signed(opnd.y);
	assign eq = opnd.x == opnd.y;

	assign res.les = {{(`ALU_WIDTH-1){1'b0}}, lt};
	assign res.gre = {{(`ALU_WIDTH-1){1'b0}}, gt};
	assign res.equ = {{(`ALU_WIDTH-1){1'b0}}, eq};

	// ********************
	// Shifts
	// ********************
	assign over   = opnd.y >= `ALU_WIDTH;
	assign sh_amt = opnd.y[$clog2(`ALU_WIDTH)-1:0];
	assign sign_x = opnd.x[`ALU_WIDTH-1];

	assign res.shl = over ? '0 : opnd.x << sh_amt;
	assign res.shr = over ? '0 : opnd.x >> sh_amt;
	assign res.srs = over ? {`ALU_WIDTH{sign_x}}
	                      : alu_word_t'($signed(opnd.x) >>> sh_amt);

endmodule

// ==== logic/alu_logic_unit.sv ====
/*
  Bitwise and truth-value ops. Logical results are exactly 0 or 1.
*/
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_logic_unit import alu_pkg::*; (
	input  alu_operands_t  opnd,
	output logic_results_t res
);

	logic x_true;  // Non-zero counts as true
	logic y_true;
	logic a_true;

	assign x_true = |opnd.x;
	assign y_true = |opnd.y;
	assign a_true = |opnd.a;

	// Bitwise
	assign res.band = opnd.x & opnd.y;
	assign res.bor  = opnd.x | opnd.y;
	assign res.bxor = opnd.x ^ opnd.y;
	assign res.inv  = ~opnd.a;

	// Logical, zero-extended flag
	assign res.lan = {{(`ALU_WIDTH-1){1'b0}}, x_true & y_true};
	assign res.lor = {{(`ALU_WIDTH-1){1'b0}}, x_true | y_true};
	assign res.lin = {{(`ALU_WIDTH-1){1'b0}}, ~a_true};

endmodule

// ==== logic/alu_int_arith.sv ====
/*
  Integer arithmetic, purely combinational.
  Two's complement; negating the most negative value wraps back to itself.
*/
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_int_arith import alu_pkg::*; (
	input  alu_operands_t opnd,
	output int_results_t  res
);

	alu_word_t neg_y;   // Shared by SGN
	alu_word_t neg_a;   // Shared by NEG and ABS
	logic      sign_x;
	logic      sign_y;
	logic      sign_a;

	assign sign_x = opnd.x[`ALU_WIDTH-1];
	assign sign_y = opnd.y[`ALU_WIDTH-1];
	assign sign_a = opnd.a[`ALU_WIDTH-1];

	assign neg_y = -opnd.y;
	assign neg_a = -opnd.a;

	// ********************
	// Two operands
	// ********************
	assign res.add = opnd.x + opnd.y;
	assign res.mlt = opnd.x * opnd.y;  // Low word, same for signed and unsigned

	// y takes the sign of x
	assign res.sgn = (sign_x == sign_y) ? opnd.y : neg_y;

	// ********************
	// Unary on a
	// ********************
	assign res.neg = neg_a;
	assign res.abs = sign_a ? neg_a : opnd.a;
	assign res.pst = sign_a ? '0 : opnd.a;  // Clamp negatives to zero

endmodule

// ==== logic/alu_operand_stage.sv ====
/*
  First pipeline register. Captures op and both operands every cycle.
  Opcodes outside the enum pass through untouched and pick in2 as unary operand.
*/
`timescale 1ns/1ps

module alu_operand_stage import alu_pkg::*; (
	input  logic          clk,
	input  logic          arst_n,
	input  alu_op_e       op,
	input  alu_word_t     in1,   // Memory side
	input  alu_word_t     in2,   // Accumulator side
	output alu_operands_t opnd
);

	alu_operands_t opnd_nxt;
	logic          use_mem;  // _M variant, unary op works on in1

	always_comb begin
		use_mem = op inside {OP_NEG_M, OP_F_NEG_M, OP_ABS_M, OP_F_ABS_M,
		                     OP_PST_M, OP_F_PST_M, OP_INV_M, OP_LIN_M};
		opnd_nxt.op = op;
		opnd_nxt.x  = in1;
		opnd_nxt.y  = in2;
		opnd_nxt.a  = use_mem ? in1 : in2;
	end

	// Cleared state decodes as NOP on zero operands
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			opnd <= '0;
		end else begin
			opnd <= opnd_nxt;
		end
	end

	// Upstream driver must always present a real opcode
	a_op_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(opnd.op));

endmodule

// ==== logic/alu_pkg.sv ====
/*
  Types shared by all ALU blocks.
  Opcode values keep the legacy numbering; gaps are unsupported ops and give 0.
*/
`include "alu_config.svh"

package alu_pkg;

	// ********************
	// Opcodes
	// ********************
	typedef enum logic [`ALU_OP_W-1:0] {
		OP_NOP     = 6'd0,  // Pass in2
		OP_LOD     = 6'd1,  // Pass in1
		OP_ADD     = 6'd2,
		OP_MLT     = 6'd4,  // Low word of product
		OP_SGN     = 6'd9,
		OP_F_SGN   = 6'd10,
		OP_NEG     = 6'd11,
		OP_NEG_M   = 6'd12,
		OP_F_NEG   = 6'd13,
		OP_F_NEG_M = 6'd14,
		OP_ABS     = 6'd15,
		OP_ABS_M   = 6'd16,
		OP_F_ABS   = 6'd17,
		OP_F_ABS_M = 6'd18,
		OP_PST     = 6'd19,
		OP_PST_M   = 6'd20,
		OP_F_PST   = 6'd21,
		OP_F_PST_M = 6'd22,
		OP_AND     = 6'd29,
		OP_ORR     = 6'd30,
		OP_XOR     = 6'd31,
		OP_INV     = 6'd32,
		OP_INV_M   = 6'd33,
		OP_LAN     = 6'd34,
		OP_LOR     = 6'd35,
		OP_LIN     = 6'd36,
		OP_LIN_M   = 6'd37,
		OP_LES     = 6'd38,
		OP_GRE     = 6'd40,
		OP_EQU     = 6'd42,
		OP_SHL     = 6'd43,
		OP_SHR     = 6'd44,
		OP_SRS     = 6'd45
	} alu_op_e;

	typedef logic [`ALU_WIDTH-1:0] alu_word_t;

	// Registered operation, a is the operand of unary ops
	typedef struct packed {
		alu_op_e   op;
		alu_word_t x;  // Memory operand
		alu_word_t y;  // Accumulator operand
		alu_word_t a;
	} alu_operands_t;

	// ********************
	// Unit results
	// ********************
	typedef struct packed {
		alu_word_t add;
		alu_word_t mlt;
		alu_word_t sgn;
		alu_word_t neg;
		alu_word_t abs;
		alu_word_t pst;
	} int_results_t;

	typedef struct packed {
		alu_word_t band;
		alu_word_t bor;
		alu_word_t bxor;
		alu_word_t inv;
		alu_word_t lan;
		alu_word_t lor;
		alu_word_t lin;
	} logic_results_t;

	typedef struct packed {
		alu_word_t les;
		alu_word_t gre;
		alu_word_t equ;
		alu_word_t shl;
		alu_word_t shr;
		alu_word_t srs;
	} cmp_results_t;

	typedef struct packed {
		alu_word_t fsgn;
		alu_word_t fneg;
		alu_word_t fabs;
		alu_word_t fpst;
	} float_results_t;

	// Sign 0, most negative exponent, mantissa 0
	localparam alu_word_t FLOAT_ZERO = {1'b0, 1'b1, {(`ALU_WIDTH-2){1'b0}}};

endpackage

// ==== logic/alu_config.svh ====
/*
  Build-time sizes for the pipelined ALU.
  Float fields must add up to the word: 1 sign + ALU_EXP + ALU_MAN.
*/
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Data path
`define ALU_WIDTH 32      // Data word
`define ALU_OP_W 6        // Opcode field

// Float layout, sign on top, no hidden bit
`define ALU_EXP 8         // Two's-complement exponent
`define ALU_MAN 23        // Mantissa

// Edges from input sample to result on out
`define ALU_LATENCY 2

`endif
